// File: verilog.f
src/soc_pkg.sv
src/bus_arbiter.sv
src/addr_decoder.sv
src/boot_rom.sv
src/scratch_mem.sv
src/clint_timer.sv
src/debug_req_gate.sv
src/soc_bus_subsystem.sv
test/soc_bus_props.sv
test/tb_soc_bus_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; fails unless the pass line is printed
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_soc_bus_subsystem -f verilog.f -Mdir obj_dir

# Echo the run to the terminal and search it for the pass line
./obj_dir/Vtb_soc_bus_subsystem | tee /dev/stderr | grep -x "sim passed" > /dev/null
echo "run_sim: pass"

// File: test/tb_soc_bus_subsystem.sv
module tb_soc_bus_subsystem;
  import soc_pkg::*;

  localparam int unsigned ScratchWords = 1024;
  localparam int unsigned DmiDelCycles = 40;
  localparam int unsigned MtimeSteps   = 3;
  // Sum of all test lengths is a few hundred cycles, so this leaves ample margin
  localparam int unsigned MaxCycles    = 4000;

  logic  clk_i;
  logic  ndmreset_n;
  logic  rtc_i;
  logic  host_req_i;
  logic  host_we_i;
  addr_t host_addr_i;
  data_t host_wdata_i;
  strb_t host_be_i;
  logic  host_gnt_o;
  logic  host_rvalid_o;
  data_t host_rdata_o;
  logic  host_err_o;
  logic  dbg_req_i;
  logic  dbg_we_i;
  addr_t dbg_addr_i;
  data_t dbg_wdata_i;
  strb_t dbg_be_i;
  logic  dbg_gnt_o;
  logic  dbg_rvalid_o;
  data_t dbg_rdata_o;
  logic  dbg_err_o;
  logic  debug_req_i;
  logic  debug_req_o;
  logic  timer_irq_o;
  logic  ipi_o;

  string       cur_test;
  int unsigned test_err_base;
  int unsigned test_count;
  int unsigned check_count;
  int unsigned err_count;
  int unsigned cycles;

  soc_bus_subsystem #(
    .ScratchWords ( ScratchWords ),
    .DmiDelCycles ( DmiDelCycles )
  ) dut_i (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles == MaxCycles) begin
      $display("timeout: run did not finish within %0d cycles", MaxCycles);
      $display("sim failed");
      $finish;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check(input string what, input data_t expected, input data_t actual);
    check_count++;
    if (expected !== actual) begin
      err_count++;
      $display("error: %s %s expected %h actual %h", cur_test, what, expected, actual);
    end
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = err_count;
  endtask

  task automatic end_test();
    test_count++;
    $display("test %s finished, %0d errors", cur_test, err_count - test_err_base);
  endtask

  // Reference merge of enabled byte lanes
  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input strb_t be);
    data_t mask;
    for (int b = 0; b < 8; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // One transaction on either master port, returns the response
  task automatic run_access(input logic use_dbg, input logic we, input addr_t addr,
                            input data_t wdata, input strb_t be,
                            output data_t rdata, output logic err);
    int unsigned lat;
    @(negedge clk_i);
    if (use_dbg) begin
      dbg_req_i   = 1'b1;
      dbg_we_i    = we;
      dbg_addr_i  = addr;
      dbg_wdata_i = wdata;
      dbg_be_i    = be;
    end else begin
      host_req_i   = 1'b1;
      host_we_i    = we;
      host_addr_i  = addr;
      host_wdata_i = wdata;
      host_be_i    = be;
    end
    #10;
    while (!(use_dbg ? dbg_gnt_o : host_gnt_o)) begin
      @(negedge clk_i);
      #10;
    end
    // Grant taken at the coming rising edge
    @(negedge clk_i);
    host_req_i = 1'b0;
    dbg_req_i  = 1'b0;
    lat = 1;
    while (!(use_dbg ? dbg_rvalid_o : host_rvalid_o)) begin
      @(negedge clk_i);
      lat++;
    end
    check("response latency", 1, lat);
    rdata = use_dbg ? dbg_rdata_o : host_rdata_o;
    err   = use_dbg ? dbg_err_o : host_err_o;
  endtask

  task automatic host_access(input logic we, input addr_t addr, input data_t wdata,
                             input strb_t be, output data_t rdata, output logic err);
    run_access(1'b0, we, addr, wdata, be, rdata, err);
  endtask

  task automatic dbg_access(input logic we, input addr_t addr, input data_t wdata,
                            input strb_t be, output data_t rdata, output logic err);
    run_access(1'b1, we, addr, wdata, be, rdata, err);
  endtask

  // Slow RTC, several clk_i cycles per phase
  task automatic rtc_edges(input int unsigned count);
    repeat (count) begin
      @(negedge clk_i);
      rtc_i = 1'b1;
      repeat (3) @(negedge clk_i);
      rtc_i = 1'b0;
      repeat (2) @(negedge clk_i);
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic debug_gate_test();
    start_test("debug gate");
    check("ipi after reset", 0, ipi_o);
    check("timer irq after reset", 0, timer_irq_o);
    check("debug_req_o after reset", 0, debug_req_o);
    for (int cyc = 1; cyc <= 45; cyc++) begin
      @(negedge clk_i);
      check("debug_req_o", (cyc >= DmiDelCycles), debug_req_o);
    end
    end_test();
  endtask

  task automatic rom_test();
    data_t       rdata;
    logic        err;
    int unsigned idx;
    start_test("rom");
    for (int i = 0; i < BootImageWords; i++) begin
      host_access(1'b0, RomBase + addr_t'(8 * i), '0, '1, rdata, err);
      check("rom word", boot_image[i], rdata);
      check("rom err", 0, err);
    end
    // Blank words past the image
    repeat (4) begin
      idx = BootImageWords + $urandom % (RomLength / 8 - BootImageWords);
      dbg_access(1'b0, RomBase + addr_t'(8 * idx), '0, '1, rdata, err);
      check("rom blank", 0, rdata);
      check("rom blank err", 0, err);
    end
    dbg_access(1'b0, 32'h4000_0000, '0, '1, rdata, err);
    check("unmapped err", 1, err);
    check("unmapped rdata", 0, rdata);
    host_access(1'b0, ScratchBase + addr_t'(ScratchWords * 8), '0, '1, rdata, err);
    check("past scratch err", 1, err);
    check("past scratch rdata", 0, rdata);
    end_test();
  endtask

  task automatic scratch_test();
    data_t base_word;
    data_t new_word;
    data_t expected;
    data_t rdata;
    logic  err;
    strb_t be;
    addr_t addr;
    start_test("scratch");
    repeat (12) begin
      addr      = ScratchBase + addr_t'(8 * ($urandom % ScratchWords));
      base_word = {$urandom, $urandom};
      new_word  = {$urandom, $urandom};
      be        = strb_t'($urandom);
      host_access(1'b1, addr, base_word, '1, rdata, err);
      host_access(1'b1, addr, new_word, be, rdata, err);
      check("write rdata", 0, rdata);
      expected = merge_bytes(base_word, new_word, be);
      dbg_access(1'b0, addr, '0, '1, rdata, err);
      check("read back", expected, rdata);
      check("read err", 0, err);
    end
    end_test();
  endtask

  task automatic arbitration_test();
    data_t       words [8];
    data_t       rdata;
    logic        err;
    logic        exp_dbg;
    int unsigned h_idx;
    int unsigned d_idx;
    start_test("arbitration");
    h_idx = 0;
    d_idx = 0;
    for (int i = 0; i < 8; i++) begin
      words[i] = {$urandom, $urandom};
      host_access(1'b1, ScratchBase + addr_t'(8 * i), words[i], '1, rdata, err);
    end
    // Host reads words 0..3, dbg reads words 4..7, both always requesting
    @(negedge clk_i);
    host_req_i  = 1'b1;
    host_we_i   = 1'b0;
    host_addr_i = ScratchBase;
    dbg_req_i   = 1'b1;
    dbg_we_i    = 1'b0;
    dbg_addr_i  = ScratchBase + 32'h20;
    for (int n = 0; n < 8; n++) begin
      exp_dbg = ((n % 2) == 1);
      #10;
      check("host grant", !exp_dbg, host_gnt_o);
      check("dbg grant", exp_dbg, dbg_gnt_o);
      @(negedge clk_i);
      if (exp_dbg) begin
        check("dbg rvalid", 1, dbg_rvalid_o);
        check("host idle", 0, host_rvalid_o);
        check("dbg rdata", words[4 + d_idx], dbg_rdata_o);
        d_idx++;
        dbg_addr_i = ScratchBase + addr_t'(8 * (4 + d_idx % 4));
      end else begin
        check("host rvalid", 1, host_rvalid_o);
        check("dbg idle", 0, dbg_rvalid_o);
        check("host rdata", words[h_idx], host_rdata_o);
        h_idx++;
        host_addr_i = ScratchBase + addr_t'(8 * (h_idx % 4));
      end
    end
    host_req_i = 1'b0;
    dbg_req_i  = 1'b0;
    end_test();
  endtask

  task automatic clint_test();
    data_t rdata;
    data_t t0;
    data_t t1;
    logic  err;
    start_test("clint");
    host_access(1'b1, ClintBase + ClintMsipOff, 64'd1, '1, rdata, err);
    check("ipi set", 1, ipi_o);
    host_access(1'b1, ClintBase + ClintMsipOff, 64'd0, '1, rdata, err);
    check("ipi clear", 0, ipi_o);
    host_access(1'b0, ClintBase + ClintMtimeOff, '0, '1, t0, err);
    rtc_edges(2 * MtimeSteps);
    host_access(1'b0, ClintBase + ClintMtimeOff, '0, '1, t1, err);
    check("mtime step", MtimeSteps, t1 - t0);
    dbg_access(1'b1, ClintBase + ClintMtimecmpOff, t1 + 2, '1, rdata, err);
    dbg_access(1'b0, ClintBase + ClintMtimecmpOff, '0, '1, rdata, err);
    check("mtimecmp readback", t1 + 2, rdata);
    // Three edges give one tick, still below compare
    rtc_edges(3);
    check("irq early", 0, timer_irq_o);
    rtc_edges(1);
    check("irq at compare", 1, timer_irq_o);
    dbg_access(1'b1, ClintBase + ClintMtimecmpOff, '1, '1, rdata, err);
    check("irq cleared", 0, timer_irq_o);
    end_test();
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    void'($urandom(32'h3f92_d2d0));
    ndmreset_n   = 1'b0;
    rtc_i        = 1'b0;
    host_req_i   = 1'b0;
    host_we_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    host_be_i    = '0;
    dbg_req_i    = 1'b0;
    dbg_we_i     = 1'b0;
    dbg_addr_i   = '0;
    dbg_wdata_i  = '0;
    dbg_be_i     = '0;
    debug_req_i  = 1'b1;
    repeat (10) @(negedge clk_i);
    ndmreset_n = 1'b1;
    // Gate test counts cycles from reset release, so it runs first
    debug_gate_test();
    rom_test();
    scratch_test();
    arbitration_test();
    clint_test();
    if (dut_i.i_bus_arbiter.props_i.fail_count != 0) begin
      $display("bus protocol assertions failed %0d times",
               dut_i.i_bus_arbiter.props_i.fail_count);
      err_count += dut_i.i_bus_arbiter.props_i.fail_count;
    end
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: test/soc_bus_props.sv
module soc_bus_props (
  input logic clk_i,
  input logic ndmreset_n,
  input logic host_req_i,
  input logic host_gnt_o,
  input logic host_rvalid_o,
  input logic dbg_req_i,
  input logic dbg_gnt_o,
  input logic dbg_rvalid_o
);

  int unsigned fail_count;

  // Single grant per cycle
  one_grant_a: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !(host_gnt_o && dbg_gnt_o))
    else begin
      $error("both masters granted in the same cycle");
      fail_count++;
    end

  // Response exactly one cycle after the grant, on the same port
  host_rsp_a: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    host_rvalid_o == $past(host_gnt_o))
    else begin
      $error("host rvalid does not follow its grant by one cycle");
      fail_count++;
    end

  dbg_rsp_a: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    dbg_rvalid_o == $past(dbg_gnt_o))
    else begin
      $error("dbg rvalid does not follow its grant by one cycle");
      fail_count++;
    end

  host_req_a: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    host_gnt_o |-> host_req_i)
    else begin
      $error("host granted without a request");
      fail_count++;
    end

  dbg_req_a: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    dbg_gnt_o |-> dbg_req_i)
    else begin
      $error("dbg granted without a request");
      fail_count++;
    end

endmodule

bind bus_arbiter soc_bus_props props_i (
  .clk_i         ( clk_i         ),
  .ndmreset_n    ( ndmreset_n    ),
  .host_req_i    ( host_req_i    ),
  .host_gnt_o    ( host_gnt_o    ),
  .host_rvalid_o ( host_rvalid_o ),
  .dbg_req_i     ( dbg_req_i     ),
  .dbg_gnt_o     ( dbg_gnt_o     ),
  .dbg_rvalid_o  ( dbg_rvalid_o  )
);

// File: src/soc_bus_subsystem.sv
module soc_bus_subsystem #(
  parameter int unsigned ScratchWords = 1024,
  parameter int unsigned DmiDelCycles = 500
) (
  input  logic           clk_i,
  input  logic           ndmreset_n,
  input  logic           rtc_i,
  // Core data port
  input  logic           host_req_i,
  input  logic           host_we_i,
  input  soc_pkg::addr_t host_addr_i,
  input  soc_pkg::data_t host_wdata_i,
  input  soc_pkg::strb_t host_be_i,
  output logic           host_gnt_o,
  output logic           host_rvalid_o,
  output soc_pkg::data_t host_rdata_o,
  output logic           host_err_o,
  // Debug module system-bus master
  input  logic           dbg_req_i,
  input  logic           dbg_we_i,
  input  soc_pkg::addr_t dbg_addr_i,
  input  soc_pkg::data_t dbg_wdata_i,
  input  soc_pkg::strb_t dbg_be_i,
  output logic           dbg_gnt_o,
  output logic           dbg_rvalid_o,
  output soc_pkg::data_t dbg_rdata_o,
  output logic           dbg_err_o,
  // Interrupts and debug request to the core
  input  logic           debug_req_i,
  output logic           debug_req_o,
  output logic           timer_irq_o,
  output logic           ipi_o
);
  import soc_pkg::*;

  logic       bus_req;
  logic       bus_we;
  addr_t      bus_addr;
  data_t      bus_wdata;
  strb_t      bus_be;
  slave_sel_e bus_sel;
  addr_t      bus_offset;
  logic       rom_req;
  logic       clint_req;
  logic       scratch_req;
  data_t      rom_rdata;
  data_t      clint_rdata;
  data_t      scratch_rdata;

  // ------------------------------
  // Arbiter and decode
  // ------------------------------
  bus_arbiter i_bus_arbiter (
    .clk_i           ( clk_i         ),
    .ndmreset_n      ( ndmreset_n    ),
    .host_req_i      ( host_req_i    ),
    .host_we_i       ( host_we_i     ),
    .host_addr_i     ( host_addr_i   ),
    .host_wdata_i    ( host_wdata_i  ),
    .host_be_i       ( host_be_i     ),
    .host_gnt_o      ( host_gnt_o    ),
    .host_rvalid_o   ( host_rvalid_o ),
    .host_rdata_o    ( host_rdata_o  ),
    .host_err_o      ( host_err_o    ),
    .dbg_req_i       ( dbg_req_i     ),
    .dbg_we_i        ( dbg_we_i      ),
    .dbg_addr_i      ( dbg_addr_i    ),
    .dbg_wdata_i     ( dbg_wdata_i   ),
    .dbg_be_i        ( dbg_be_i      ),
    .dbg_gnt_o       ( dbg_gnt_o     ),
    .dbg_rvalid_o    ( dbg_rvalid_o  ),
    .dbg_rdata_o     ( dbg_rdata_o   ),
    .dbg_err_o       ( dbg_err_o     ),
    .bus_req_o       ( bus_req       ),
    .bus_we_o        ( bus_we        ),
    .bus_addr_o      ( bus_addr      ),
    .bus_wdata_o     ( bus_wdata     ),
    .bus_be_o        ( bus_be        ),
    .bus_sel_i       ( bus_sel       ),
    .rom_rdata_i     ( rom_rdata     ),
    .clint_rdata_i   ( clint_rdata   ),
    .scratch_rdata_i ( scratch_rdata )
  );

  addr_decoder #(
    .ScratchWords ( ScratchWords )
  ) i_addr_decoder (
    .addr_i   ( bus_addr   ),
    .sel_o    ( bus_sel    ),
    .offset_o ( bus_offset )
  );

  // One-hot slave strobes
  assign rom_req     = bus_req & (bus_sel == sel_rom);
  assign clint_req   = bus_req & (bus_sel == sel_clint);
  assign scratch_req = bus_req & (bus_sel == sel_scratch);

  // ------------------------------
  // Slaves
  // ------------------------------
  boot_rom i_boot_rom (
    .clk_i    ( clk_i      ),
    .req_i    ( rom_req    ),
    .offset_i ( bus_offset ),
    .rdata_o  ( rom_rdata  )
  );

  scratch_mem #(
    .ScratchWords ( ScratchWords )
  ) i_scratch_mem (
    .clk_i    ( clk_i         ),
    .req_i    ( scratch_req   ),
    .we_i     ( bus_we        ),
    .offset_i ( bus_offset    ),
    .wdata_i  ( bus_wdata     ),
    .be_i     ( bus_be        ),
    .rdata_o  ( scratch_rdata )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .we_i        ( bus_we      ),
    .offset_i    ( bus_offset  ),
    .wdata_i     ( bus_wdata   ),
    .be_i        ( bus_be      ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  debug_req_gate #(
    .DmiDelCycles ( DmiDelCycles )
  ) i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: src/debug_req_gate.sv
module debug_req_gate #(
  parameter int unsigned DmiDelCycles = 500
) (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned CntWidth = (DmiDelCycles > 0) ? $clog2(DmiDelCycles + 1) : 1;

  logic [CntWidth-1:0] del_cnt_q;

  // Gives the core time to run boot code before debug can halt it
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      del_cnt_q <= CntWidth'(DmiDelCycles);
    end else if (del_cnt_q != '0) begin
      del_cnt_q <= del_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (del_cnt_q == '0) & debug_req_i;

endmodule

// File: src/clint_timer.sv
module clint_timer (
  input  logic           clk_i,
  input  logic           ndmreset_n,
  input  logic           rtc_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t offset_i,
  input  soc_pkg::data_t wdata_i,
  input  soc_pkg::strb_t be_i,
  output soc_pkg::data_t rdata_o,
  output logic           timer_irq_o,
  output logic           ipi_o
);
  import soc_pkg::*;

  logic       msip_q;
  data_t      mtimecmp_q;
  data_t      mtime_q;
  data_t      rdata_q;
  logic [1:0] rtc_sync_q;
  logic       rtc_last_q;
  logic       rtc_half_q;
  logic       rtc_rise;
  logic       mtime_tick;

  // ------------------------------
  // RTC synchroniser and divider
  // ------------------------------
  assign rtc_rise   = rtc_sync_q[1] & ~rtc_last_q;
  // Every second rising edge
  assign mtime_tick = rtc_rise & rtc_half_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= 2'b00;
      rtc_last_q <= 1'b0;
      rtc_half_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_last_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        rtc_half_q <= ~rtc_half_q;
      end
    end
  end

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
    end else begin
      if (mtime_tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      // A software write to mtime wins over the tick
      if (req_i && we_i) begin
        case (offset_i)
          ClintMsipOff: begin
            if (be_i[0]) begin
              msip_q <= wdata_i[0];
            end
          end
          ClintMtimecmpOff: mtimecmp_q <= apply_be(mtimecmp_q, wdata_i, be_i);
          ClintMtimeOff:    mtime_q    <= apply_be(mtime_q, wdata_i, be_i);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (offset_i)
        ClintMsipOff:     rdata_q <= {{(DataWidth-1){1'b0}}, msip_q};
        ClintMtimecmpOff: rdata_q <= mtimecmp_q;
        ClintMtimeOff:    rdata_q <= mtime_q;
        default:          rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o     = rdata_q;
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

// File: src/scratch_mem.sv
module scratch_mem #(
  parameter int unsigned ScratchWords = 1024
) (
  input  logic           clk_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t offset_i,
  input  soc_pkg::data_t wdata_i,
  input  soc_pkg::strb_t be_i,
  output soc_pkg::data_t rdata_o
);
  import soc_pkg::*;

  localparam int unsigned IdxWidth = (ScratchWords > 1) ? $clog2(ScratchWords) : 1;

  data_t                mem [ScratchWords];
  logic  [IdxWidth-1:0] word_idx;
  data_t                rdata_q;

  // Region-relative byte offset to word index
  assign word_idx = offset_i[IdxWidth+2:3];

  // ------------------------------
  // Write and read port
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[word_idx] <= apply_be(mem[word_idx], wdata_i, be_i);
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: src/boot_rom.sv
module boot_rom (
  input  logic           clk_i,
  input  logic           req_i,
  input  soc_pkg::addr_t offset_i,
  output soc_pkg::data_t rdata_o
);
  import soc_pkg::*;

  localparam int unsigned IdxWidth = $clog2(BootImageWords);

  addr_t word_idx;
  data_t rdata_q;

  // 8 bytes per word
  assign word_idx = offset_i >> 3;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (word_idx < BootImageWords) begin
        rdata_q <= boot_image[word_idx[IdxWidth-1:0]];
      end else begin
        // Rest of the ROM region is blank
        rdata_q <= '0;
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: src/addr_decoder.sv
module addr_decoder #(
  parameter int unsigned ScratchWords = 1024
) (
  input  soc_pkg::addr_t      addr_i,
  output soc_pkg::slave_sel_e sel_o,
  output soc_pkg::addr_t      offset_o
);
  import soc_pkg::*;

  localparam addr_t ScratchLength = addr_t'(ScratchWords * 8);

  addr_t rom_off;
  addr_t clint_off;
  addr_t scratch_off;

  // Below-base addresses wrap to large offsets and fail the length test
  assign rom_off     = addr_i - RomBase;
  assign clint_off   = addr_i - ClintBase;
  assign scratch_off = addr_i - ScratchBase;

  // ------------------------------
  // Region match
  // ------------------------------
  always_comb begin
    sel_o    = sel_none;
    offset_o = addr_i;
    if (rom_off < RomLength) begin
      sel_o    = sel_rom;
      offset_o = rom_off;
    end else if (clint_off < ClintLength) begin
      sel_o    = sel_clint;
      offset_o = clint_off;
    end else if (scratch_off < ScratchLength) begin
      sel_o    = sel_scratch;
      offset_o = scratch_off;
    end
  end

endmodule

// File: src/bus_arbiter.sv
module bus_arbiter (
  input  logic                   clk_i,
  input  logic                   ndmreset_n,
  // Core data port
  input  logic                   host_req_i,
  input  logic                   host_we_i,
  input  soc_pkg::addr_t         host_addr_i,
  input  soc_pkg::data_t         host_wdata_i,
  input  soc_pkg::strb_t         host_be_i,
  output logic                   host_gnt_o,
  output logic                   host_rvalid_o,
  output soc_pkg::data_t         host_rdata_o,
  output logic                   host_err_o,
  // Debug module system-bus master
  input  logic                   dbg_req_i,
  input  logic                   dbg_we_i,
  input  soc_pkg::addr_t         dbg_addr_i,
  input  soc_pkg::data_t         dbg_wdata_i,
  input  soc_pkg::strb_t         dbg_be_i,
  output logic                   dbg_gnt_o,
  output logic                   dbg_rvalid_o,
  output soc_pkg::data_t         dbg_rdata_o,
  output logic                   dbg_err_o,
  // Shared bus
  output logic                   bus_req_o,
  output logic                   bus_we_o,
  output soc_pkg::addr_t         bus_addr_o,
  output soc_pkg::data_t         bus_wdata_o,
  output soc_pkg::strb_t         bus_be_o,
  input  soc_pkg::slave_sel_e    bus_sel_i,
  input  soc_pkg::data_t         rom_rdata_i,
  input  soc_pkg::data_t         clint_rdata_i,
  input  soc_pkg::data_t         scratch_rdata_i
);
  import soc_pkg::*;

  logic       prio_dbg_q;
  logic       rsp_valid_q;
  logic       rsp_dbg_q;
  logic       rsp_we_q;
  slave_sel_e rsp_sel_q;
  data_t      rsp_rdata;
  logic       rsp_err;

  // ------------------------------
  // Round-robin grant
  // ------------------------------
  assign host_gnt_o = host_req_i & ~(dbg_req_i & prio_dbg_q);
  assign dbg_gnt_o  = dbg_req_i & ~(host_req_i & ~prio_dbg_q);

  // Winner drives the shared bus
  assign bus_req_o   = host_req_i | dbg_req_i;
  assign bus_we_o    = dbg_gnt_o ? dbg_we_i    : host_we_i;
  assign bus_addr_o  = dbg_gnt_o ? dbg_addr_i  : host_addr_i;
  assign bus_wdata_o = dbg_gnt_o ? dbg_wdata_i : host_wdata_i;
  assign bus_be_o    = dbg_gnt_o ? dbg_be_i    : host_be_i;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      prio_dbg_q  <= 1'b0;
      rsp_valid_q <= 1'b0;
      rsp_dbg_q   <= 1'b0;
      rsp_we_q    <= 1'b0;
      rsp_sel_q   <= sel_none;
    end else begin
      // Loser of a contested cycle goes first next time
      if (host_req_i && dbg_req_i) begin
        prio_dbg_q <= host_gnt_o;
      end
      rsp_valid_q <= bus_req_o;
      if (bus_req_o) begin
        rsp_dbg_q <= dbg_gnt_o;
        rsp_we_q  <= bus_we_o;
        rsp_sel_q <= bus_sel_i;
      end
    end
  end

  // ------------------------------
  // Response routing
  // ------------------------------
  always_comb begin
    unique case (rsp_sel_q)
      sel_rom:     rsp_rdata = rom_rdata_i;
      sel_clint:   rsp_rdata = clint_rdata_i;
      sel_scratch: rsp_rdata = scratch_rdata_i;
      default:     rsp_rdata = '0;
    endcase
    // writes answer with zero data
    if (rsp_we_q) begin
      rsp_rdata = '0;
    end
  end

  assign rsp_err = (rsp_sel_q == sel_none);

  assign host_rvalid_o = rsp_valid_q & ~rsp_dbg_q;
  assign dbg_rvalid_o  = rsp_valid_q & rsp_dbg_q;
  assign host_rdata_o  = rsp_rdata;
  assign dbg_rdata_o   = rsp_rdata;
  assign host_err_o    = host_rvalid_o & rsp_err;
  assign dbg_err_o     = dbg_rvalid_o & rsp_err;

endmodule

// File: src/soc_pkg.sv
package soc_pkg;

  // ------------------------------
  // Bus geometry
  // ------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // Decoded bus target
  typedef enum logic [1:0] {
    sel_rom     = 2'd0,
    sel_clint   = 2'd1,
    sel_scratch = 2'd2,
    sel_none    = 2'd3
  } slave_sel_e;

  // ------------------------------
  // Address map
  // ------------------------------
  localparam addr_t RomBase     = 32'h0000_1000;
  localparam addr_t RomLength   = 32'h0000_1000;
  localparam addr_t ClintBase   = 32'h0200_0000;
  localparam addr_t ClintLength = 32'h0000_C000;
  localparam addr_t ScratchBase = 32'h8000_0000;

  // CLINT register offsets
  localparam addr_t ClintMsipOff     = 32'h0000_0000;
  localparam addr_t ClintMtimecmpOff = 32'h0000_4000;
  localparam addr_t ClintMtimeOff    = 32'h0000_BFF8;

  // Boot image, two instructions per word
  localparam int unsigned BootImageWords = 16;
  localparam data_t boot_image [BootImageWords] = '{
    64'h0000_0297_f140_2573, 64'h0182_b283_0202_8593, 64'h0000_0013_0002_8067,
    64'h1050_0073_0000_0013, 64'hffdf_f06f_1050_0073, 64'h0000_0000_8000_0000,
    64'h0000_0000_0000_1020, 64'h0030_0513_0010_0493, 64'h00a4_8533_0005_0593,
    64'h0200_02b7_0042_8293, 64'h0002_a023_0000_0013, 64'h3020_0073_0000_0013,
    64'hdead_beef_cafe_f00d, 64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210,
    64'h5a5a_a5a5_0f0f_f0f0
  };

  // Byte-lane merge for byte-enable writes
  function automatic data_t apply_be(data_t old_word, data_t new_word, strb_t be);
    data_t merged;
    merged = old_word;
    for (int i = 0; i < StrbWidth; i++) begin
      if (be[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage
